// File: riscv_core_div.sv
module riscv_core_div
(
  input  logic                                i_clk,
  input  logic                                i_rst,
  input  logic                                i_start,
  input  riscv_core_div_pkg::div_req_t        i_req,
  output logic                                o_busy,
  output logic                                o_done,
  output logic [riscv_core_div_pkg::XLEN-1:0] o_result
);

riscv_core_div_pkg::div_operands_t operands;
riscv_core_div_pkg::div_raw_t      raw;
logic                              raw_valid;

// Operand conditioning, purely combinational
riscv_core_div_in div_in_i
(
  .i_req      (i_req),
  .o_operands (operands)
);

riscv_core_div_iter div_iter_i
(
  .i_clk       (i_clk),
  .i_rst       (i_rst),
  .i_start     (i_start),
  .i_operands  (operands),
  .o_busy      (o_busy),
  .o_raw_valid (raw_valid),
  .o_raw       (raw)
);

// Sign fix-up and special results, registered toward the core
riscv_core_div_out div_out_i
(
  .i_clk       (i_clk),
  .i_rst       (i_rst),
  .i_raw_valid (raw_valid),
  .i_raw       (raw),
  .o_done      (o_done),
  .o_result    (o_result)
);

endmodule

// File: riscv_core_div_in.sv
module riscv_core_div_in
(
  input  riscv_core_div_pkg::div_req_t      i_req,
  output riscv_core_div_pkg::div_operands_t o_operands
);

logic                                signed_op;
logic [riscv_core_div_pkg::XLEN-1:0] a_eff;
logic [riscv_core_div_pkg::XLEN-1:0] b_eff;
logic [riscv_core_div_pkg::XLEN-1:0] a_mag;
logic [riscv_core_div_pkg::XLEN-1:0] b_mag;
logic [riscv_core_div_pkg::XLEN-1:0] a_min;
logic [1:0]                          a_b_neg;

always_comb
  begin: op_proc
    case (i_req.op)
      riscv_core_div_pkg::DIV,
      riscv_core_div_pkg::REM:
        begin
          signed_op = 1'b1;
        end
      riscv_core_div_pkg::DIVU,
      riscv_core_div_pkg::REMU:
        begin
          signed_op = 1'b0;
        end
      default:
        begin
          signed_op = 1'b0;
        end
    endcase
  end

// W forms only look at the low word of each source
always_comb
  begin: ext_proc
    if (!i_req.isword)
      begin
        a_eff = i_req.srcA;
        b_eff = i_req.srcB;
        a_min = {1'b1, {(riscv_core_div_pkg::XLEN-1){1'b0}}};
      end
    else if (signed_op)
      begin
        a_eff = {{(riscv_core_div_pkg::XLEN-riscv_core_div_pkg::WLEN){
                  i_req.srcA[riscv_core_div_pkg::WLEN-1]}},
                 i_req.srcA[riscv_core_div_pkg::WLEN-1:0]};
        b_eff = {{(riscv_core_div_pkg::XLEN-riscv_core_div_pkg::WLEN){
                  i_req.srcB[riscv_core_div_pkg::WLEN-1]}},
                 i_req.srcB[riscv_core_div_pkg::WLEN-1:0]};
        a_min = {{(riscv_core_div_pkg::XLEN-riscv_core_div_pkg::WLEN+1){1'b1}},
                 {(riscv_core_div_pkg::WLEN-1){1'b0}}};
      end
    else
      begin
        a_eff = {{(riscv_core_div_pkg::XLEN-riscv_core_div_pkg::WLEN){1'b0}},
                 i_req.srcA[riscv_core_div_pkg::WLEN-1:0]};
        b_eff = {{(riscv_core_div_pkg::XLEN-riscv_core_div_pkg::WLEN){1'b0}},
                 i_req.srcB[riscv_core_div_pkg::WLEN-1:0]};
        a_min = {{(riscv_core_div_pkg::XLEN-riscv_core_div_pkg::WLEN+1){1'b1}},
                 {(riscv_core_div_pkg::WLEN-1){1'b0}}};
      end
  end

assign a_b_neg = {signed_op & a_eff[riscv_core_div_pkg::XLEN-1],
                  signed_op & b_eff[riscv_core_div_pkg::XLEN-1]};

always_comb
  begin: mag_proc
    case (a_b_neg)
      2'b01:
        begin
          a_mag = a_eff;
          b_mag = -b_eff;
        end
      2'b10:
        begin
          a_mag = -a_eff;
          b_mag = b_eff;
        end
      2'b11:
        begin
          a_mag = -a_eff;
          b_mag = -b_eff;
        end
      default:
        begin
          a_mag = a_eff;
          b_mag = b_eff;
        end
    endcase
  end

always_comb
  begin: out_proc
    o_operands.dividend       = a_mag;
    o_operands.divisor        = b_mag;
    o_operands.neg_quot       = a_b_neg[1] ^ a_b_neg[0];
    o_operands.neg_rem        = a_b_neg[1];
    o_operands.fast.b_zero    = (b_eff == '0);
    o_operands.fast.b_one     = (b_eff == {{(riscv_core_div_pkg::XLEN-1){1'b0}}, 1'b1});
    o_operands.fast.b_neg_one = signed_op & (&b_eff);
    o_operands.fast.a_zero    = (a_eff == '0);
    // Most negative value over minus one does not fit, the ISA defines the result
    o_operands.fast.overflow  = signed_op & (a_eff == a_min) & (&b_eff);
    o_operands.is_rem         = (i_req.op == riscv_core_div_pkg::REM) ||
                                (i_req.op == riscv_core_div_pkg::REMU);
    o_operands.isword         = i_req.isword;
    o_operands.src_a_eff      = a_eff;
  end

endmodule

// File: riscv_core_div_iter.sv
module riscv_core_div_iter
(
  input  logic                              i_clk,
  input  logic                              i_rst,
  input  logic                              i_start,
  input  riscv_core_div_pkg::div_operands_t i_operands,
  output logic                              o_busy,
  output logic                              o_raw_valid,
  output riscv_core_div_pkg::div_raw_t      o_raw
);

riscv_core_div_pkg::div_state_e      state_q;
riscv_core_div_pkg::div_state_e      state_d;
logic [riscv_core_div_pkg::CNT_W-1:0] cnt_q;
riscv_core_div_pkg::div_operands_t   opr_q;
logic [riscv_core_div_pkg::XLEN-1:0] dvd_q;
logic [riscv_core_div_pkg::XLEN-1:0] rem_q;
logic [riscv_core_div_pkg::XLEN-1:0] quot_q;
logic [riscv_core_div_pkg::XLEN:0]   rem_shift;
logic [riscv_core_div_pkg::XLEN:0]   diff;
logic [riscv_core_div_pkg::XLEN-1:0] rem_next;
logic                                q_bit;
logic                                accept;

assign accept = (state_q == riscv_core_div_pkg::IDLE) && i_start;

always_comb
  begin: next_proc
    state_d = state_q;
    case (state_q)
      riscv_core_div_pkg::IDLE:
        begin
          if (i_start)
            state_d = (|i_operands.fast) ? riscv_core_div_pkg::FINISH :
                                            riscv_core_div_pkg::RUN;
        end
      riscv_core_div_pkg::RUN:
        begin
          if (cnt_q == riscv_core_div_pkg::ITER_LAST)
            state_d = riscv_core_div_pkg::FINISH;
        end
      riscv_core_div_pkg::FINISH:
        begin
          state_d = riscv_core_div_pkg::IDLE;
        end
      default:
        begin
          state_d = riscv_core_div_pkg::IDLE;
        end
    endcase
  end

always_ff @(posedge i_clk)
  begin: ctrl_proc
    if (i_rst)
      begin
        state_q <= riscv_core_div_pkg::IDLE;
        cnt_q   <= '0;
      end
    else
      begin
        state_q <= state_d;
        if (accept)
          cnt_q <= i_operands.isword ? riscv_core_div_pkg::ITER_WORD :
                                       riscv_core_div_pkg::ITER_FULL;
        else if (state_q == riscv_core_div_pkg::RUN)
          cnt_q <= cnt_q - riscv_core_div_pkg::ITER_LAST;
      end
  end

// One restoring step brings in the next dividend bit and tries the subtraction
assign rem_shift = {rem_q, dvd_q[riscv_core_div_pkg::XLEN-1]};
assign diff      = rem_shift - {1'b0, opr_q.divisor};
assign q_bit     = ~diff[riscv_core_div_pkg::XLEN];
assign rem_next  = q_bit ? diff[riscv_core_div_pkg::XLEN-1:0] :
                           rem_shift[riscv_core_div_pkg::XLEN-1:0];

always_ff @(posedge i_clk)
  begin: data_proc
    if (accept)
      begin
        opr_q  <= i_operands;
        // Word forms start with the low word in the top half so 32 steps suffice
        dvd_q  <= i_operands.isword ?
                  {i_operands.dividend[riscv_core_div_pkg::WLEN-1:0],
                   {(riscv_core_div_pkg::XLEN-riscv_core_div_pkg::WLEN){1'b0}}} :
                  i_operands.dividend;
        rem_q  <= '0;
        quot_q <= '0;
      end
    else if (state_q == riscv_core_div_pkg::RUN)
      begin
        dvd_q  <= {dvd_q[riscv_core_div_pkg::XLEN-2:0], 1'b0};
        rem_q  <= rem_next;
        quot_q <= {quot_q[riscv_core_div_pkg::XLEN-2:0], q_bit};
      end
  end

assign o_busy      = (state_q != riscv_core_div_pkg::IDLE);
assign o_raw_valid = (state_q == riscv_core_div_pkg::FINISH);

always_comb
  begin: raw_proc
    o_raw.quotient  = quot_q;
    o_raw.remainder = rem_q;
    o_raw.neg_quot  = opr_q.neg_quot;
    o_raw.neg_rem   = opr_q.neg_rem;
    o_raw.fast      = opr_q.fast;
    o_raw.is_rem    = opr_q.is_rem;
    o_raw.isword    = opr_q.isword;
    o_raw.src_a_eff = opr_q.src_a_eff;
  end

a_raw_valid_single: assert property (@(posedge i_clk) disable iff (i_rst)
  o_raw_valid |=> !o_raw_valid);

a_cnt_no_underflow: assert property (@(posedge i_clk) disable iff (i_rst)
  (state_q == riscv_core_div_pkg::RUN) |-> (cnt_q != '0));

// The restoring loop keeps the partial remainder below the divisor
a_rem_below_divisor: assert property (@(posedge i_clk) disable iff (i_rst)
  (state_q == riscv_core_div_pkg::RUN) |-> (rem_q < opr_q.divisor));

endmodule

// File: riscv_core_div_out.sv
module riscv_core_div_out
(
  input  logic                                i_clk,
  input  logic                                i_rst,
  input  logic                                i_raw_valid,
  input  riscv_core_div_pkg::div_raw_t        i_raw,
  output logic                                o_done,
  output logic [riscv_core_div_pkg::XLEN-1:0] o_result
);

logic [riscv_core_div_pkg::XLEN-1:0] q_signed;
logic [riscv_core_div_pkg::XLEN-1:0] r_signed;
logic [riscv_core_div_pkg::XLEN-1:0] quot;
logic [riscv_core_div_pkg::XLEN-1:0] rem;
logic [riscv_core_div_pkg::XLEN-1:0] sel;
logic [riscv_core_div_pkg::XLEN-1:0] result_d;

assign q_signed = i_raw.neg_quot ? -i_raw.quotient : i_raw.quotient;
assign r_signed = i_raw.neg_rem ? -i_raw.remainder : i_raw.remainder;

// The fast cases never ran the loop, so their raw magnitudes are ignored here
always_comb
  begin: special_proc
    quot = q_signed;
    rem  = r_signed;
    if (i_raw.fast.b_zero)
      begin
        quot = '1;
        rem  = i_raw.src_a_eff;
      end
    else if (i_raw.fast.overflow)
      begin
        quot = i_raw.src_a_eff;
        rem  = '0;
      end
    else if (i_raw.fast.b_one)
      begin
        quot = i_raw.src_a_eff;
        rem  = '0;
      end
    else if (i_raw.fast.b_neg_one)
      begin
        quot = -i_raw.src_a_eff;
        rem  = '0;
      end
    else if (i_raw.fast.a_zero)
      begin
        quot = '0;
        rem  = '0;
      end
  end

assign sel = i_raw.is_rem ? rem : quot;

// W forms return the low word sign-extended even for unsigned ops
always_comb
  begin: word_proc
    if (i_raw.isword)
      result_d = {{(riscv_core_div_pkg::XLEN-riscv_core_div_pkg::WLEN){
                   sel[riscv_core_div_pkg::WLEN-1]}},
                  sel[riscv_core_div_pkg::WLEN-1:0]};
    else
      result_d = sel;
  end

always_ff @(posedge i_clk)
  begin: out_proc
    if (i_rst)
      begin
        o_done   <= 1'b0;
        o_result <= '0;
      end
    else
      begin
        o_done <= i_raw_valid;
        if (i_raw_valid)
          o_result <= result_d;
      end
  end

// Word magnitudes from the loop never reach into the upper half that the sign extension drops
a_word_fits: assert property (@(posedge i_clk) disable iff (i_rst)
  (i_raw_valid && i_raw.isword) |->
    ((i_raw.quotient[riscv_core_div_pkg::XLEN-1:riscv_core_div_pkg::WLEN] == '0) &&
     (i_raw.remainder[riscv_core_div_pkg::XLEN-1:riscv_core_div_pkg::WLEN] == '0)));

endmodule

// File: riscv_core_div_pkg.sv
package riscv_core_div_pkg;

// Register width and the width used by the W forms
localparam int XLEN  = 64;
localparam int WLEN  = 32;

// Iteration counter, wide enough to hold a full-width count of 64
localparam int CNT_W = 7;

localparam logic [CNT_W-1:0] ITER_FULL = 7'd64;
localparam logic [CNT_W-1:0] ITER_WORD = 7'd32;
localparam logic [CNT_W-1:0] ITER_LAST = 7'd1;

// Control field of the divide instruction, isword selects the W form
typedef enum logic [1:0]
{
  DIV  = 2'd0,
  DIVU = 2'd1,
  REM  = 2'd2,
  REMU = 2'd3
} div_op_e;

typedef enum logic [1:0]
{
  IDLE   = 2'd0,
  RUN    = 2'd1,
  FINISH = 2'd2
} div_state_e;

typedef struct packed
{
  logic [XLEN-1:0] srcA;
  logic [XLEN-1:0] srcB;
  div_op_e         op;
  logic            isword;
} div_req_t;

// Cases resolved without running the shift-subtract loop
typedef struct packed
{
  logic b_zero;
  logic b_one;
  logic b_neg_one;
  logic a_zero;
  logic overflow;
} div_fast_t;

typedef struct packed
{
  logic [XLEN-1:0] dividend;
  logic [XLEN-1:0] divisor;
  logic            neg_quot;
  logic            neg_rem;
  div_fast_t       fast;
  logic            is_rem;
  logic            isword;
  logic [XLEN-1:0] src_a_eff;
} div_operands_t;

typedef struct packed
{
  logic [XLEN-1:0] quotient;
  logic [XLEN-1:0] remainder;
  logic            neg_quot;
  logic            neg_rem;
  div_fast_t       fast;
  logic            is_rem;
  logic            isword;
  logic [XLEN-1:0] src_a_eff;
} div_raw_t;

endpackage

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f src.f --top-module tb_riscv_core_div
output=$(./obj_dir/Vtb_riscv_core_div)
echo "$output"
if echo "$output" | grep -q "Simulation PASSED"
then
  exit 0
fi
exit 1

// File: src.f
+incdir+.
riscv_core_div_pkg.sv
riscv_core_div_in.sv
riscv_core_div_iter.sv
riscv_core_div_out.sv
riscv_core_div.sv
tb_riscv_core_div.sv

// File: tb_riscv_core_div_vectors.svh
task automatic load_vectors();
  // Columns are srcA, srcB, op, isword and the expected result
  add_vector(64'sd20, 64'sd6, riscv_core_div_pkg::DIV, 1'b0, 64'sd3);
  add_vector(-64'sd20, 64'sd6, riscv_core_div_pkg::DIV, 1'b0, -64'sd3);
  add_vector(64'sd20, -64'sd6, riscv_core_div_pkg::DIV, 1'b0, -64'sd3);
  add_vector(-64'sd20, -64'sd6, riscv_core_div_pkg::DIV, 1'b0, 64'sd3);
  add_vector(64'sd20, 64'sd6, riscv_core_div_pkg::REM, 1'b0, 64'sd2);
  add_vector(-64'sd20, 64'sd6, riscv_core_div_pkg::REM, 1'b0, -64'sd2);
  add_vector(64'sd20, -64'sd6, riscv_core_div_pkg::REM, 1'b0, 64'sd2);
  add_vector(-64'sd20, -64'sd6, riscv_core_div_pkg::REM, 1'b0, -64'sd2);
  add_vector(-64'sd1, 64'd2, riscv_core_div_pkg::DIVU, 1'b0, 64'h7fffffffffffffff);
  add_vector(-64'sd1, 64'd10, riscv_core_div_pkg::REMU, 1'b0, 64'd5);
  add_vector(64'd100, 64'd7, riscv_core_div_pkg::DIVU, 1'b0, 64'd14);
  add_vector(64'd100, 64'd7, riscv_core_div_pkg::REMU, 1'b0, 64'd2);
  add_vector(-64'sd5, 64'd0, riscv_core_div_pkg::DIV, 1'b0, -64'sd1);
  add_vector(64'd123, 64'd0, riscv_core_div_pkg::DIVU, 1'b0, -64'sd1);
  add_vector(-64'sd5, 64'd0, riscv_core_div_pkg::REM, 1'b0, -64'sd5);
  add_vector(64'd123, 64'd0, riscv_core_div_pkg::REMU, 1'b0, 64'd123);
  add_vector(64'h8000000000000000, -64'sd1, riscv_core_div_pkg::DIV, 1'b0,
             64'h8000000000000000);
  add_vector(64'h8000000000000000, -64'sd1, riscv_core_div_pkg::REM, 1'b0, 64'd0);
  add_vector(64'd0, 64'd7, riscv_core_div_pkg::DIV, 1'b0, 64'd0);
  add_vector(64'sd9, -64'sd1, riscv_core_div_pkg::DIV, 1'b0, -64'sd9);
  add_vector(64'hfedcba9876543210, 64'd1, riscv_core_div_pkg::DIVU, 1'b0, 64'hfedcba9876543210);
  add_vector(64'hdeadbeef00000014, 64'h12345678fffffffa, riscv_core_div_pkg::DIV, 1'b1, -64'sd3);
  add_vector(64'h00000001ffffffec, 64'd6, riscv_core_div_pkg::REM, 1'b1, -64'sd2);
  add_vector(64'h80000000, 64'd2, riscv_core_div_pkg::DIVU, 1'b1, 64'd1073741824);
  add_vector(64'hfffffff0, 64'hfffffff5, riscv_core_div_pkg::REMU, 1'b1, -64'sd16);
  add_vector(64'hfffffffe, 64'd1, riscv_core_div_pkg::DIVU, 1'b1, -64'sd2);
  add_vector(64'h80000005, 64'h100000000, riscv_core_div_pkg::DIV, 1'b1, -64'sd1);
  add_vector(64'h80000005, 64'h100000000, riscv_core_div_pkg::REM, 1'b1, 64'hffffffff80000005);
  add_vector(64'h80000005, 64'h100000000, riscv_core_div_pkg::REMU, 1'b1, 64'hffffffff80000005);
  add_vector(64'h80000000, 64'hffffffff, riscv_core_div_pkg::DIV, 1'b1, 64'hffffffff80000000);
  add_vector(64'h80000000, 64'hffffffff, riscv_core_div_pkg::REM, 1'b1, 64'd0);
  add_vector(64'h100000007, 64'h500000002, riscv_core_div_pkg::DIVU, 1'b1, 64'd3);
endtask

// File: tb_riscv_core_div.sv
module tb_riscv_core_div;

localparam int unsigned SEED       = 32'h4be63d99;
localparam int          RAND_COUNT = 200;
localparam int          TIMEOUT    = 200;

typedef struct packed
{
  riscv_core_div_pkg::div_req_t        req;
  logic [riscv_core_div_pkg::XLEN-1:0] expected;
} vector_t;

logic                                clk = 1'b0;
logic                                rst;
logic                                start;
riscv_core_div_pkg::div_req_t        req_in;
logic                                busy;
logic                                done;
logic [riscv_core_div_pkg::XLEN-1:0] result;

vector_t vectors[$];
int      checks = 0;
int      errors = 0;
int      timeouts = 0;

riscv_core_div dut_i
(
  .i_clk    (clk),
  .i_rst    (rst),
  .i_start  (start),
  .i_req    (req_in),
  .o_busy   (busy),
  .o_done   (done),
  .o_result (result)
);

always #20 clk = ~clk;

function automatic void add_vector(input logic [63:0] a, input logic [63:0] b,
                                   input riscv_core_div_pkg::div_op_e op,
                                   input logic isword, input logic [63:0] expected);
  vector_t v;
  v.req.srcA   = a;
  v.req.srcB   = b;
  v.req.op     = op;
  v.req.isword = isword;
  v.expected   = expected;
  vectors.push_back(v);
endfunction

`include "tb_riscv_core_div_vectors.svh"

// ISA result of one request, plus the latency that the fast-case rules predict
function automatic logic [63:0] ref_model(input riscv_core_div_pkg::div_req_t req,
                                          output int latency);
  logic               sgn;
  logic signed [63:0] a;
  logic signed [63:0] b;
  logic [63:0]        quot;
  logic [63:0]        rem;
  logic [63:0]        res;
  logic               fast;
  sgn = (req.op == riscv_core_div_pkg::DIV) || (req.op == riscv_core_div_pkg::REM);
  a   = req.srcA;
  b   = req.srcB;
  if (req.isword)
    begin
      a = {{32{sgn & req.srcA[31]}}, req.srcA[31:0]};
      b = {{32{sgn & req.srcB[31]}}, req.srcB[31:0]};
    end
  if (b == 64'sd0)
    begin
      quot = '1;
      rem  = a;
    end
  else if (sgn && (a == 64'sh8000000000000000) && (b == -64'sd1))
    begin
      quot = a;
      rem  = '0;
    end
  else if (sgn)
    begin
      quot = a / b;
      rem  = a % b;
    end
  else
    begin
      quot = $unsigned(a) / $unsigned(b);
      rem  = $unsigned(a) % $unsigned(b);
    end
  res = ((req.op == riscv_core_div_pkg::REM) || (req.op == riscv_core_div_pkg::REMU)) ?
        rem : quot;
  // A word result keeps 32 bits, even when the op is unsigned
  if (req.isword)
    res = {{32{res[31]}}, res[31:0]};
  fast    = (b == 64'sd0) || (b == 64'sd1) || (sgn && (b == -64'sd1)) || (a == 64'sd0);
  latency = fast ? 2 : (req.isword ? 34 : 66);
  return res;
endfunction

task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                           input string what);
  checks++;
  if (actual !== expected)
    begin
      errors++;
      $display("error at time %0t: %s, got %h, expected %h", $time, what, actual, expected);
    end
endtask

task automatic run_op(input riscv_core_div_pkg::div_req_t req, input logic [63:0] expected,
                      input string tag);
  int          cycles;
  int          latency;
  logic [63:0] held;
  void'(ref_model(req, latency));
  @(posedge clk);
  req_in <= req;
  start  <= 1'b1;
  @(negedge clk);
  check_value(64'(busy), 64'd0, $sformatf("%s busy in start cycle", tag));
  @(posedge clk);
  start  <= 1'b0;
  req_in <= '0;
  cycles = 1;
  @(negedge clk);
  while (!done && (cycles < TIMEOUT))
    begin
      check_value(64'(busy), 64'd1, $sformatf("%s busy in cycle %0d", tag, cycles));
      @(negedge clk);
      cycles++;
    end
  if (!done)
    begin
      errors++;
      timeouts++;
      $display("%s: no done pulse within %0d cycles of the start", tag, TIMEOUT);
    end
  else
    begin
      check_value(64'(cycles), 64'(latency), $sformatf("%s done latency", tag));
      check_value(result, expected, $sformatf("%s result", tag));
      check_value(64'(busy), 64'd0, $sformatf("%s busy at done", tag));
      held = result;
      repeat (3)
        begin
          @(negedge clk);
          check_value(64'(done), 64'd0, $sformatf("%s done after pulse", tag));
          check_value(result, held, $sformatf("%s result hold", tag));
        end
    end
endtask

initial
  begin: main_proc
    int                           idx;
    int                           pick;
    int                           latency;
    riscv_core_div_pkg::div_req_t req;
    rst    <= 1'b1;
    start  <= 1'b0;
    req_in <= '0;
    void'($urandom(SEED));
    load_vectors();
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_value(64'(busy), 64'd0, "busy after reset");
    check_value(64'(done), 64'd0, "done after reset");
    check_value(result, 64'd0, "result after reset");
    for (idx = 0; idx < vectors.size(); idx++)
      run_op(vectors[idx].req, vectors[idx].expected, $sformatf("vector %0d", idx));
    for (idx = 0; idx < RAND_COUNT; idx++)
      begin
        req.srcA   = {$urandom, $urandom};
        req.srcB   = {$urandom, $urandom};
        req.op     = riscv_core_div_pkg::div_op_e'(2'($urandom_range(3, 0)));
        req.isword = 1'($urandom_range(1, 0));
        pick       = $urandom_range(7, 0);
        // Steer some requests into divide by zero, overflow and small divisors
        if (pick == 0)
          req.srcB = '0;
        else if (pick == 1)
          begin
            req.srcA = req.isword ? 64'h80000000 : 64'h8000000000000000;
            req.srcB = '1;
          end
        else if (pick == 2)
          req.srcB = 64'($urandom_range(15, 0));
        run_op(req, ref_model(req, latency), $sformatf("random %0d", idx));
      end
    $display("%0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule
